// ==== Makefile ====
# Verilator build and run of the rename testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f all.f --top-module rename_tb \
		-Mdir obj_dir -o rename_sim

run: compile
	./obj_dir/rename_sim

clean:
	rm -rf obj_dir

// ==== all.f ====
source/rename_pkg.sv
source/free_list.sv
source/checkpoint_bank.sv
source/rename_map.sv
source/rename_queue.sv
source/rename_top.sv
bench/rename_tb.sv

// ==== bench/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;

    localparam opcode_t op_reg      = 7'b0110011;   // register-register ALU
    localparam int      test_cycles = 1500;         // estimated length of all tests

    logic      clk;
    logic      reset;
    logic      instr_valid;
    opcode_t   opcode;
    arch_reg_t src1_reg;
    arch_reg_t src2_reg;
    arch_reg_t dest_reg;
    logic      save_state;
    page_t     save_page;
    logic      restore_state;
    page_t     restore_page;
    logic      commit_valid;
    phys_tag_t commit_tag;
    logic      out_pop;
    logic      stall;
    logic      out_valid;
    phys_tag_t out_src1_tag;
    phys_tag_t out_src2_tag;
    phys_tag_t out_dest_tag;
    phys_tag_t out_prev_tag;
    arch_reg_t out_dest_reg;

    phys_tag_t   model_map  [num_arch];
    phys_tag_t   model_ring [num_phys];
    head_t       model_head;
    head_t       model_tail;
    int          model_count;               // free tags in the model ring
    phys_tag_t   page_map   [num_pages][num_arch];
    head_t       page_head  [num_pages];
    renamed_op_t exp_q [$];
    phys_tag_t   commit_pool [$];           // prev tags of ops already popped
    logic        exp_stall;
    logic        exp_valid;
    int          seed;
    int          issued;
    renamed_op_t got_op;
    renamed_op_t exp_op;

    rename_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_op(input renamed_op_t got, input renamed_op_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: renamed op got src %0d/%0d dest %0d prev %0d rd x%0d",
                     $time, got.src1_tag, got.src2_tag, got.dest_tag, got.prev_tag,
                     got.dest_reg);
            $display("      expected src %0d/%0d dest %0d prev %0d rd x%0d",
                     exp.src1_tag, exp.src2_tag, exp.dest_tag, exp.prev_tag, exp.dest_reg);
            $display("ERRORS FOUND");
            $fatal(1, "renamed op mismatch");
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic arch_reg_t rand_reg();
        return arch_reg_t'(rand_below(num_arch));
    endfunction

    function automatic opcode_t op_by_index(input int k);
        case (k)
            0:       return op_jalr;
            1:       return op_load;
            2:       return op_imm;
            3:       return op_lui;
            4:       return op_auipc;
            5:       return op_jal;
            6:       return op_branch;
            7:       return op_store;
            default: return op_reg;
        endcase
    endfunction

    // expected op for one rename, advancing the model map and ring
    function automatic renamed_op_t rename_ref(input opcode_t op, input arch_reg_t s1,
                                               input arch_reg_t s2, input arch_reg_t d);
        renamed_op_t r;
        r.src1_tag = model_map[s1];
        r.src2_tag = model_map[s2];
        r.dest_reg = d;
        if (op == op_jalr || op == op_load || op == op_imm) begin
            r.src2_tag = no_src_tag;
        end else if (op == op_lui || op == op_auipc || op == op_jal) begin
            r.src1_tag = '0;            // x0 lives in tag 0
            r.src2_tag = no_src_tag;
        end
        if (op == op_branch || op == op_store || d == '0) begin
            r.dest_tag = no_dest_tag;
            r.prev_tag = no_dest_tag;
        end else begin
            r.dest_tag   = model_ring[model_head];
            r.prev_tag   = model_map[d];
            model_map[d] = r.dest_tag;
            model_head   = model_head + 1'b1;
            model_count  = model_count - 1;
        end
        return r;
    endfunction

    // one clock of stimulus on the falling edge, model follows the next rising edge
    task automatic run_cycle(input logic instr, input opcode_t op, input arch_reg_t s1,
                             input arch_reg_t s2, input arch_reg_t d, input logic pop,
                             input logic commit, input logic save, input logic restore,
                             input page_t page);
        @(negedge clk);
        exp_stall     = (model_count == 0) || (exp_q.size() == queue_depth);
        exp_valid     = (exp_q.size() != 0);
        instr_valid   = instr && !exp_stall && !restore;
        opcode        = op;
        src1_reg      = s1;
        src2_reg      = s2;
        dest_reg      = d;
        out_pop       = pop && exp_valid && !restore;
        commit_valid  = commit && (commit_pool.size() != 0);
        save_state    = save;
        save_page     = page;
        restore_state = restore;
        restore_page  = page;
        if (instr_valid) begin
            exp_q.push_back(rename_ref(op, s1, s2, d));
            issued++;
        end
        if (commit_valid) begin
            commit_tag             = commit_pool.pop_front();
            model_ring[model_tail] = commit_tag;    // back in at the tail
            model_tail             = model_tail + 1'b1;
            model_count            = model_count + 1;
        end
        if (save) begin
            page_map[page]  = model_map;
            page_head[page] = model_head;           // head after this edge's allocation
        end
        if (restore) begin
            model_map   = page_map[page];
            model_head  = page_head[page];
            model_count = int'(head_t'(model_tail - model_head));
            exp_q.delete();                         // younger ops squashed
        end
    endtask

    task automatic rename(input opcode_t op, input arch_reg_t s1, input arch_reg_t s2,
                          input arch_reg_t d, input logic pop);
        run_cycle(1'b1, op, s1, s2, d, pop, 1'b0, 1'b0, 1'b0, 3'd0);
    endtask

    task automatic idle(input logic pop, input logic commit);
        run_cycle(1'b0, op_reg, 5'd0, 5'd0, 5'd0, pop, commit, 1'b0, 1'b0, 3'd0);
    endtask

    task automatic drain(input logic release_all);
        while (exp_q.size() != 0) begin
            idle(1'b1, 1'b0);
        end
        idle(1'b0, 1'b0);
        while (release_all && commit_pool.size() != 0) begin
            idle(1'b0, 1'b1);
        end
    endtask

    task automatic restore_and_rename(input page_t page);
        run_cycle(1'b0, op_reg, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1, page);
        for (int i = 0; i < 3; i++) begin
            rename(op_by_index(rand_below(9)), rand_reg(), rand_reg(), rand_reg(), 1'b1);
        end
    endtask

    // compare every popped op and the status levels before each edge
    always @(posedge clk) begin
        if (!reset) begin
            check_level(stall, exp_stall, "stall");
            check_level(out_valid, exp_valid, "out_valid");
            if (out_pop) begin
                got_op = {out_src1_tag, out_src2_tag, out_dest_tag, out_prev_tag, out_dest_reg};
                exp_op = exp_q.pop_front();
                check_op(got_op, exp_op);
                if (exp_op.prev_tag != no_dest_tag) begin
                    commit_pool.push_back(exp_op.prev_tag);
                end
            end
        end
    end

    initial begin
        #(test_cycles * 100 * 2);
        $display("timeout: the run did not finish within %0d clock cycles", test_cycles * 2);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed          = 34;
        issued        = 0;
        reset         = 1'b1;
        instr_valid   = 1'b0;
        opcode        = op_reg;
        src1_reg      = '0;
        src2_reg      = '0;
        dest_reg      = '0;
        save_state    = 1'b0;
        save_page     = '0;
        restore_state = 1'b0;
        restore_page  = '0;
        commit_valid  = 1'b0;
        commit_tag    = '0;
        out_pop       = 1'b0;
        exp_stall     = 1'b0;
        exp_valid     = 1'b0;
        for (int i = 0; i < num_phys; i++) begin
            model_ring[i] = (i < num_free) ? phys_tag_t'(num_arch + i) : '0;
        end
        for (int i = 0; i < num_arch; i++) begin
            model_map[i] = phys_tag_t'(i);
        end
        model_head  = '0;
        model_tail  = head_t'(num_free);
        model_count = num_free;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        for (int i = 1; i <= 4; i++) begin      // identity sources, tags 32 up
            rename(op_reg, arch_reg_t'(i), arch_reg_t'(i + 4), arch_reg_t'(i + 10), 1'b1);
        end
        rename(op_reg, 5'd11, 5'd12, 5'd11, 1'b1);
        for (int k = 0; k < 9; k++) begin       // every opcode class
            rename(op_by_index(k), 5'd3, 5'd11, 5'd20, 1'b1);
            rename(op_by_index(k), 5'd20, 5'd4, 5'd0, 1'b1);
        end

        while (model_count != 0) begin          // empty the free list
            rename(op_reg, rand_reg(), rand_reg(), arch_reg_t'(1 + rand_below(31)), 1'b1);
        end
        idle(1'b1, 1'b0);
        idle(1'b1, 1'b0);
        idle(1'b1, 1'b1);                       // one commit frees a tag
        rename(op_reg, 5'd1, 5'd2, 5'd9, 1'b1);

        issued = 0;
        while (issued < 500) begin
            run_cycle(rand_below(4) != 0, op_by_index(rand_below(9)), rand_reg(), rand_reg(),
                      rand_reg(), rand_below(2) != 0, rand_below(2) != 0, 1'b0, 1'b0, 3'd0);
        end
        drain(1'b1);

        // save together with a rename, then roll back
        run_cycle(1'b1, op_reg, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1, 1'b0, 3'd0);
        for (int i = 4; i < 9; i++) begin
            rename(op_reg, arch_reg_t'(i - 1), 5'd3, arch_reg_t'(i), 1'b0);
        end
        run_cycle(1'b0, op_reg, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd0);
        for (int i = 4; i < 9; i++) begin
            rename(op_reg, arch_reg_t'(i), 5'd3, arch_reg_t'(i), 1'b1);
        end
        drain(1'b0);

        for (int p = 1; p < 4; p++) begin
            run_cycle(1'b0, op_reg, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b1, 1'b0, page_t'(p));
            for (int i = 0; i < 3; i++) begin
                rename(op_by_index(rand_below(9)), rand_reg(), rand_reg(), rand_reg(), 1'b1);
            end
        end
        restore_and_rename(3'd3);
        restore_and_rename(3'd1);
        restore_and_rename(3'd2);
        drain(1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== source/checkpoint_bank.sv ====
`timescale 1ns/1ps

module checkpoint_bank (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              save,
    input  rename_pkg::page_t                                 save_page,
    input  rename_pkg::phys_tag_t [rename_pkg::num_arch-1:0] save_table,
    input  rename_pkg::head_t                                 save_head,
    input  logic                                              restore,
    input  rename_pkg::page_t                                 restore_page,
    output rename_pkg::phys_tag_t [rename_pkg::num_arch-1:0] restore_table,
    output rename_pkg::head_t                                 restore_head
);
    import rename_pkg::*;

    phys_tag_t [num_arch-1:0] page_table [num_pages];
    head_t                    page_head  [num_pages];
    logic [num_pages-1:0]     page_valid;

    // snapshot storage
    always_ff @(posedge clk) begin
        if (save) begin
            page_table[save_page] <= save_table;
            page_head[save_page]  <= save_head;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            page_valid <= '0;
        end else if (save) begin
            page_valid[save_page] <= 1'b1;
        end
    end

    assign restore_table = page_table[restore_page];    // combinational read
    assign restore_head  = page_head[restore_page];

    // a page must hold a snapshot before anyone rolls back to it
    restore_of_valid_page: assert property (
        @(posedge clk) disable iff (reset)
        restore |-> page_valid[restore_page]
    );

endmodule

// ==== source/free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic                  release_valid,
    input  rename_pkg::phys_tag_t release_tag,
    input  logic                  rollback,
    input  rename_pkg::head_t     rollback_head,
    output rename_pkg::phys_tag_t free_tag,
    output logic                  free_empty,
    output rename_pkg::head_t     head
);
    import rename_pkg::*;

    phys_tag_t  ring [num_phys];
    head_t      tail;
    head_t      tail_next;
    logic [6:0] count;          // free tags between head and tail

    assign tail_next  = tail + head_t'(release_valid);
    assign free_tag   = ring[head];    // head slot always on view
    assign free_empty = (count == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_phys; i++) begin
                ring[i] <= (i < num_free) ? phys_tag_t'(num_arch + i) : '0;
            end
        end else if (release_valid) begin
            ring[tail] <= release_tag;     // commit returns a tag at the tail
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= head_t'(num_free);
            count <= 7'(num_free);
        end else begin
            tail <= tail_next;
            if (rollback) begin
                // 64 slots and at most 32 free tags, so the
                // pointer difference alone gives the count
                head  <= rollback_head;
                count <= {1'b0, head_t'(tail_next - rollback_head)};
            end else begin
                if (alloc) begin
                    head <= head + 1'b1;
                end
                count <= count + 7'(release_valid) - 7'(alloc);
            end
        end
    end

    no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        alloc |-> !free_empty
    );

    no_release_when_full: assert property (
        @(posedge clk) disable iff (reset)
        release_valid |-> (count != 7'(num_free))
    );

endmodule

// ==== source/rename_map.sv ====
`timescale 1ns/1ps

module rename_map (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  rename_pkg::opcode_t   opcode,
    input  rename_pkg::arch_reg_t src1_reg,
    input  rename_pkg::arch_reg_t src2_reg,
    input  rename_pkg::arch_reg_t dest_reg,
    input  logic                  save_state,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore_state,
    input  rename_pkg::page_t     restore_page,
    input  rename_pkg::phys_tag_t free_tag,
    input  logic                  free_empty,
    input  rename_pkg::head_t     head,
    input  logic                  queue_full,
    output logic                  stall,
    output logic                  alloc,
    output logic                  rollback,
    output rename_pkg::head_t     rollback_head,
    output logic                  flush,
    output logic                  push,
    output rename_pkg::phys_tag_t push_src1,
    output rename_pkg::phys_tag_t push_src2,
    output rename_pkg::phys_tag_t push_dest,
    output rename_pkg::phys_tag_t push_prev,
    output rename_pkg::arch_reg_t push_dest_reg
);
    import rename_pkg::*;

    phys_tag_t [num_arch-1:0] map_table;
    phys_tag_t [num_arch-1:0] table_upd;    // table after this cycle's rename
    phys_tag_t [num_arch-1:0] snap_table;
    head_t                    snap_head;
    logic                     accept;
    logic                     has_dest;

    assign stall  = free_empty || queue_full;
    assign accept = instr_valid && !restore_state && !stall;

    // source lookup reads the table before the destination update
    always_comb begin
        case (opcode)
            op_jalr, op_load, op_imm: begin
                push_src1 = map_table[src1_reg];
                push_src2 = no_src_tag;
            end
            op_lui, op_auipc, op_jal: begin
                push_src1 = '0;                  // x0 is fixed at tag 0
                push_src2 = no_src_tag;
            end
            default: begin
                push_src1 = map_table[src1_reg];
                push_src2 = map_table[src2_reg];
            end
        endcase
    end

    assign has_dest = (opcode != op_branch) && (opcode != op_store) && (dest_reg != '0);

    assign alloc         = accept && has_dest;
    assign push          = accept;
    assign push_dest     = has_dest ? free_tag : no_dest_tag;
    assign push_prev     = has_dest ? map_table[dest_reg] : no_dest_tag;
    assign push_dest_reg = dest_reg;

    always_comb begin
        table_upd = map_table;
        if (alloc) begin
            table_upd[dest_reg] = free_tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_arch; i++) begin
                map_table[i] <= phys_tag_t'(i);     // identity mapping
            end
        end else if (restore_state) begin
            map_table <= snap_table;
        end else begin
            map_table <= table_upd;
        end
    end

    // snapshot sees the rename of the same edge
    checkpoint_bank ckpt0 (
        .clk           (clk),
        .reset         (reset),
        .save          (save_state),
        .save_page     (save_page),
        .save_table    (table_upd),
        .save_head     (head + head_t'(alloc)),
        .restore       (restore_state),
        .restore_page  (restore_page),
        .restore_table (snap_table),
        .restore_head  (snap_head)
    );

    assign rollback      = restore_state;
    assign rollback_head = snap_head;
    assign flush         = restore_state;   // younger ops are squashed

    // the front end honours stall, so nothing is ever silently dropped
    no_instr_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (instr_valid && !restore_state) |-> !stall
    );

endmodule

// ==== source/rename_pkg.sv ====
package rename_pkg;

    typedef logic [4:0] arch_reg_t;
    typedef logic [7:0] phys_tag_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] page_t;
    typedef logic [5:0] head_t;         // ring pointer into 64 slots

    localparam int num_arch    = 32;
    localparam int num_phys    = 64;
    localparam int num_free    = num_phys - num_arch;  // tags in the ring after reset
    localparam int num_pages   = 8;
    localparam int queue_depth = 8;

    localparam phys_tag_t no_src_tag  = 8'd254;   // operand unused
    localparam phys_tag_t no_dest_tag = 8'd255;   // nothing written

    // major opcodes that change the rename rules
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_store  = 7'b0100011;

    // one queue entry, 37 bits
    typedef struct packed {
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        phys_tag_t dest_tag;
        phys_tag_t prev_tag;    // released at commit
        arch_reg_t dest_reg;
    } renamed_op_t;

endpackage

// ==== source/rename_queue.sv ====
`timescale 1ns/1ps

module rename_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  rename_pkg::phys_tag_t push_src1,
    input  rename_pkg::phys_tag_t push_src2,
    input  rename_pkg::phys_tag_t push_dest,
    input  rename_pkg::phys_tag_t push_prev,
    input  rename_pkg::arch_reg_t push_dest_reg,
    input  logic                  pop,
    input  logic                  flush,
    output logic                  full,
    output logic                  out_valid,
    output rename_pkg::phys_tag_t out_src1_tag,
    output rename_pkg::phys_tag_t out_src2_tag,
    output rename_pkg::phys_tag_t out_dest_tag,
    output rename_pkg::phys_tag_t out_prev_tag,
    output rename_pkg::arch_reg_t out_dest_reg
);
    import rename_pkg::*;

    renamed_op_t                     entries [queue_depth];
    renamed_op_t                     head_op;
    logic [$clog2(queue_depth)-1:0]  wr_ptr;
    logic [$clog2(queue_depth)-1:0]  rd_ptr;
    logic [$clog2(queue_depth):0]    count;

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            entries[wr_ptr] <= '{src1_tag: push_src1, src2_tag: push_src2,
                                 dest_tag: push_dest, prev_tag: push_prev,
                                 dest_reg: push_dest_reg};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin       // flush wins over push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    assign full      = (count == queue_depth);
    assign out_valid = (count != '0);

    // show-ahead head entry
    assign head_op      = entries[rd_ptr];
    assign out_src1_tag = head_op.src1_tag;
    assign out_src2_tag = head_op.src2_tag;
    assign out_dest_tag = head_op.dest_tag;
    assign out_prev_tag = head_op.prev_tag;
    assign out_dest_reg = head_op.dest_reg;

    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> !full
    );

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> out_valid
    );

endmodule

// ==== source/rename_top.sv ====
`timescale 1ns/1ps

module rename_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  rename_pkg::opcode_t   opcode,
    input  rename_pkg::arch_reg_t src1_reg,
    input  rename_pkg::arch_reg_t src2_reg,
    input  rename_pkg::arch_reg_t dest_reg,
    input  logic                  save_state,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore_state,
    input  rename_pkg::page_t     restore_page,
    input  logic                  commit_valid,
    input  rename_pkg::phys_tag_t commit_tag,
    input  logic                  out_pop,
    output logic                  stall,
    output logic                  out_valid,
    output rename_pkg::phys_tag_t out_src1_tag,
    output rename_pkg::phys_tag_t out_src2_tag,
    output rename_pkg::phys_tag_t out_dest_tag,
    output rename_pkg::phys_tag_t out_prev_tag,
    output rename_pkg::arch_reg_t out_dest_reg
);
    import rename_pkg::*;

    phys_tag_t free_tag;
    logic      free_empty;
    head_t     head;
    logic      alloc;
    logic      rollback;
    head_t     rollback_head;
    logic      flush;
    logic      push;
    phys_tag_t push_src1;
    phys_tag_t push_src2;
    phys_tag_t push_dest;
    phys_tag_t push_prev;
    arch_reg_t push_dest_reg;
    logic      queue_full;

    free_list free0 (
        .clk           (clk),
        .reset         (reset),
        .alloc         (alloc),
        .release_valid (commit_valid),     // commit hands back the previous tag
        .release_tag   (commit_tag),
        .rollback      (rollback),
        .rollback_head (rollback_head),
        .free_tag      (free_tag),
        .free_empty    (free_empty),
        .head          (head)
    );

    rename_map map0 (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .opcode        (opcode),
        .src1_reg      (src1_reg),
        .src2_reg      (src2_reg),
        .dest_reg      (dest_reg),
        .save_state    (save_state),
        .save_page     (save_page),
        .restore_state (restore_state),
        .restore_page  (restore_page),
        .free_tag      (free_tag),
        .free_empty    (free_empty),
        .head          (head),
        .queue_full    (queue_full),
        .stall         (stall),
        .alloc         (alloc),
        .rollback      (rollback),
        .rollback_head (rollback_head),
        .flush         (flush),
        .push          (push),
        .push_src1     (push_src1),
        .push_src2     (push_src2),
        .push_dest     (push_dest),
        .push_prev     (push_prev),
        .push_dest_reg (push_dest_reg)
    );

    rename_queue queue0 (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_src1     (push_src1),
        .push_src2     (push_src2),
        .push_dest     (push_dest),
        .push_prev     (push_prev),
        .push_dest_reg (push_dest_reg),
        .pop           (out_pop),
        .flush         (flush),
        .full          (queue_full),
        .out_valid     (out_valid),
        .out_src1_tag  (out_src1_tag),
        .out_src2_tag  (out_src2_tag),
        .out_dest_tag  (out_dest_tag),
        .out_prev_tag  (out_prev_tag),
        .out_dest_reg  (out_dest_reg)
    );

endmodule
